// File: list.f
common/wbPkg.sv
rtl/wbStageReg.sv
rtl/loadFormatter.sv
rtl/hiLoRegs.sv
rtl/gprFile.sv
rtl/wbUnit.sv
bench/wbChecker.sv
bench/wbUnitTb.sv

// File: run.sh
#!/bin/sh
# build the writeback tail testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module wbUnitTb -Mdir obj_dir -f list.f \
    && ./obj_dir/VwbUnitTb | tee /dev/stderr | grep -q "=== PASS ===" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: bench/wbUnitTb.sv
////////////////////
// testbench for the writeback tail
// clock, reset, stimulus, reference model and watchdog
////////////////////

`default_nettype none

module wbUnitTb;

    import wbPkg::*;

    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 16;
    // reset, resultLoad, hiLo, flush, stall, bypass
    localparam int TOTAL_STEPS   = 16 + 78 + 35 + 10 + 11 + 10;
    localparam int WATCHDOG_TIME = (TOTAL_STEPS * 4 + RESET_CYCLES) * CLK_PERIOD;

    logic                  clk;
    logic                  reset;
    logic                  wbFlush;
    logic                  wbWr;
    wbBundle               mem2Bundle;
    logic [REG_ADDR_W-1:0] rdAddrA;
    logic [REG_ADDR_W-1:0] rdAddrB;
    logic [31:0]           rdDataA;
    logic [31:0]           rdDataB;
    logic [31:0]           hi;
    logic [31:0]           lo;

    // expectations handed to the checker
    logic        chkEn;
    logic [95:0] testName;
    logic [31:0] expA;
    logic [31:0] expB;
    logic [31:0] expHi;
    logic [31:0] expLo;
    int          checkCount;
    int          errCount;
    int          errAtStart;
    int          checksAtStart;

    // reference state
    logic [31:0] modelRegs [REG_COUNT];
    logic [31:0] modelHi;
    logic [31:0] modelLo;
    logic [5:0]  loadOps [5];

    wbUnit dut0 (
        .clk        (clk),
        .reset      (reset),
        .wbFlush    (wbFlush),
        .wbWr       (wbWr),
        .mem2Bundle (mem2Bundle),
        .rdAddrA    (rdAddrA),
        .rdAddrB    (rdAddrB),
        .rdDataA    (rdDataA),
        .rdDataB    (rdDataB),
        .hi         (hi),
        .lo         (lo)
    );

    wbChecker chk0 (
        .clk        (clk),
        .chkEn      (chkEn),
        .testName   (testName),
        .expA       (expA),
        .expB       (expB),
        .expHi      (expHi),
        .expLo      (expLo),
        .rdDataA    (rdDataA),
        .rdDataB    (rdDataB),
        .hi         (hi),
        .lo         (lo),
        .checkCount (checkCount),
        .errCount   (errCount)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: the tests did not finish within %0d time units", WATCHDOG_TIME);
        $display("=== FAIL ===");
        $finish;
    end

    ////////////////////
    // reference model
    ////////////////////

    // little-endian lane pick, then extension by opcode
    function automatic logic [31:0] refLoad(logic [5:0] op, logic [1:0] off, logic [31:0] word);
        logic [7:0]  lane8;
        logic [15:0] lane16;
        lane8  = word[8 * off +: 8];
        lane16 = word[16 * off[1] +: 16];
        case (op)
            OP_LB:   return {{24{lane8[7]}}, lane8};
            OP_LBU:  return {24'h0, lane8};
            OP_LH:   return {{16{lane16[15]}}, lane16};
            OP_LHU:  return {16'h0, lane16};
            default: return word;
        endcase
    endfunction

    function automatic logic [31:0] refWbValue(wbBundle b, logic [31:0] curHi,
                                               logic [31:0] curLo);
        case (b.wbSel)
            WB_SEL_LOAD: return refLoad(b.instr.iType.opcode, b.result[1:0], b.dmOut);
            WB_SEL_HI:   return curHi;
            WB_SEL_LO:   return curLo;
            default:     return b.result;
        endcase
    endfunction

    // wr is {rfWr, hiWr, loWr, cp0Wr}
    function automatic wbBundle makeBundle(logic [5:0] op, logic [5:0] funct, logic [1:0] sel,
                                           logic [4:0] dst, logic [3:0] wr);
        wbBundle b;
        b.pc                 = $urandom();
        b.instr.rType.opcode = op;
        b.instr.rType.rs     = 5'($urandom());
        b.instr.rType.rt     = 5'($urandom());
        b.instr.rType.rd     = dst;
        b.instr.rType.shamt  = 5'd0;
        b.instr.rType.funct  = funct;
        b.wbSel              = sel;
        b.dst                = dst;
        b.dmOut              = $urandom();
        b.outB               = $urandom();
        b.regsWr             = regsWrType'(wr);
        b.result             = $urandom();
        return b;
    endfunction

    // addu, a plain ALU result
    function automatic wbBundle makeResult(logic [4:0] dst);
        return makeBundle(6'd0, 6'b100001, WB_SEL_RESULT, dst, 4'b1000);
    endfunction

    ////////////////////
    // stimulus
    ////////////////////

    // present one bundle, check while its write is pending, then let it commit
    task automatic applyStep(input wbBundle b, input logic flush, input logic wr,
                             input logic [4:0] addrA, input logic [4:0] addrB);
        logic accepted;
        accepted = wr && !flush;
        @(posedge clk);
        #1;
        mem2Bundle = b;
        wbFlush    = flush;
        wbWr       = wr;
        rdAddrA    = addrA;
        rdAddrB    = addrB;
        @(posedge clk);
        #1;
        wbFlush = 1'b0;
        wbWr    = 1'b0;
        if (accepted && b.regsWr.rfWr && (b.dst != '0)) begin
            modelRegs[b.dst] = refWbValue(b, modelHi, modelLo);
        end
        expA  = modelRegs[addrA];
        expB  = modelRegs[addrB];
        expHi = modelHi;
        expLo = modelLo;
        chkEn = 1'b1;
        @(negedge clk);
        #1;
        chkEn = 1'b0;
        // HI and LO land one edge after the read check
        if (accepted && b.regsWr.hiWr) begin
            modelHi = b.outB;
        end
        if (accepted && b.regsWr.loWr) begin
            modelLo = (b.instr.rType.funct == FN_MTLO) ? b.outB : b.result;
        end
    endtask

    // mfhi or mflo into a random register
    task automatic moveFromHiLo(input logic [1:0] sel);
        wbBundle b;
        logic [5:0] funct;
        funct = (sel == WB_SEL_HI) ? 6'b010000 : 6'b010010;
        b = makeBundle(6'd0, funct, sel, 5'($urandom()), 4'b1000);
        applyStep(b, 1'b0, 1'b1, b.dst, 5'($urandom()));
    endtask

    task automatic startTest(input logic [95:0] name);
        testName      = name;
        errAtStart    = errCount;
        checksAtStart = checkCount;
    endtask

    task automatic finishTest();
        $display("test %0s done, %0d checks, %0d errors", testName,
                 checkCount - checksAtStart, errCount - errAtStart);
    endtask

    initial begin
        wbBundle    b;
        logic [4:0] dst;
        logic       legal;
        void'($urandom(32'h60fb5fdc));
        reset      = 1'b1;
        wbFlush    = 1'b0;
        wbWr       = 1'b0;
        mem2Bundle = '0;
        rdAddrA    = '0;
        rdAddrB    = '0;
        chkEn      = 1'b0;
        testName   = "init";
        expA       = '0;
        expB       = '0;
        expHi      = '0;
        expLo      = '0;
        modelHi    = '0;
        modelLo    = '0;
        loadOps    = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
        for (int i = 0; i < REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        // every register on one of the two ports
        startTest("reset");
        for (int i = 0; i < 16; i++) begin
            applyStep('0, 1'b0, 1'b1, 5'(2 * i), 5'(2 * i + 1));
        end
        finishTest();

        // each load opcode at each aligned offset, with ALU results between
        startTest("resultLoad");
        for (int rep = 0; rep < 3; rep++) begin
            for (int k = 0; k < 5; k++) begin
                for (int off = 0; off < 4; off++) begin
                    legal = (loadOps[k] == OP_LW) ? (off == 0) :
                            (loadOps[k] == OP_LH || loadOps[k] == OP_LHU) ? (off % 2 == 0) :
                            1'b1;
                    if (legal) begin
                        dst = (rep == 1 && off == 0) ? 5'd0 : 5'($urandom());
                        b = makeBundle(loadOps[k], 6'($urandom()), WB_SEL_LOAD, dst, 4'b1000);
                        b.result[1:0] = 2'(off);
                        applyStep(b, 1'b0, 1'b1, b.dst, 5'($urandom()));
                        b = makeResult(5'($urandom()));
                        applyStep(b, 1'b0, 1'b1, b.dst, 5'($urandom()));
                    end
                end
            end
        end
        finishTest();

        startTest("hiLo");
        for (int n = 0; n < 5; n++) begin
            b = makeBundle(6'd0, FN_MTHI, WB_SEL_RESULT, 5'($urandom()), 4'b0100);
            applyStep(b, 1'b0, 1'b1, b.dst, 5'($urandom()));
            b = makeBundle(6'd0, FN_MTLO, WB_SEL_RESULT, 5'($urandom()), 4'b0010);
            applyStep(b, 1'b0, 1'b1, b.dst, 5'($urandom()));
            moveFromHiLo(WB_SEL_HI);
            moveFromHiLo(WB_SEL_LO);
            b = makeBundle(6'd0, (n % 2 == 0) ? FN_MULT : FN_MULTU, WB_SEL_RESULT,
                           5'($urandom()), 4'b0110);
            applyStep(b, 1'b0, 1'b1, b.dst, 5'($urandom()));
            moveFromHiLo(WB_SEL_HI);
            moveFromHiLo(WB_SEL_LO);
        end
        finishTest();

        // flushed multiplies and ALU results leave no trace
        startTest("flush");
        for (int i = 0; i < 10; i++) begin
            if (i % 2 == 0) begin
                b = makeBundle(6'd0, FN_MULT, WB_SEL_RESULT, 5'($urandom()), 4'b0110);
            end else begin
                b = makeResult(5'($urandom()));
            end
            applyStep(b, 1'b1, 1'b1, b.dst, 5'($urandom()));
        end
        finishTest();

        startTest("stall");
        b = makeResult(5'($urandom()));
        applyStep(b, 1'b0, 1'b1, b.dst, 5'($urandom()));
        for (int i = 0; i < 8; i++) begin
            if (i % 2 == 0) begin
                b = makeResult(5'($urandom()));
            end else begin
                b = makeBundle(6'd0, FN_MTHI, WB_SEL_RESULT, 5'($urandom()), 4'b0100);
            end
            applyStep(b, 1'b0, 1'b0, b.dst, 5'($urandom()));
        end
        for (int i = 0; i < 2; i++) begin
            b = makeResult(5'($urandom()));
            applyStep(b, 1'b0, 1'b1, b.dst, 5'($urandom()));
        end
        finishTest();

        // back-to-back writes to one register, both ports on it
        startTest("bypass");
        dst = 5'(1 + $urandom() % 31);
        for (int i = 0; i < 10; i++) begin
            b = makeResult(dst);
            applyStep(b, 1'b0, 1'b1, dst, dst);
        end
        finishTest();

        $display("total checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/wbChecker.sv
////////////////////
// checker for the writeback tail
// compares read ports and HI/LO with the expected values
////////////////////

`default_nettype none

module wbChecker (
    input  wire logic        clk,
    input  wire logic        chkEn,
    input  wire logic [95:0] testName,
    input  wire logic [31:0] expA,
    input  wire logic [31:0] expB,
    input  wire logic [31:0] expHi,
    input  wire logic [31:0] expLo,
    input  wire logic [31:0] rdDataA,
    input  wire logic [31:0] rdDataB,
    input  wire logic [31:0] hi,
    input  wire logic [31:0] lo,
    output int               checkCount,
    output int               errCount
);

    initial begin
        checkCount = 0;
        errCount   = 0;
    end

    task automatic compareWord(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errCount++;
            $display("ERR %0s %0s expected %08h actual %08h",
                     testName, what, expected, actual);
        end
    endtask

    ////////////////////
    // sampling
    ////////////////////

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (chkEn) begin
            compareWord("rdDataA", expA, rdDataA);
            compareWord("rdDataB", expB, rdDataB);
            compareWord("hi", expHi, hi);
            compareWord("lo", expLo, lo);
        end
    end

endmodule

`default_nettype wire

// File: rtl/wbUnit.sv
////////////////////
// writeback tail top level
// stage register, load formatter, HI/LO pair and register file
////////////////////

`default_nettype none

module wbUnit (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        wbFlush,
    input  wire logic                        wbWr,
    input  wire wbPkg::wbBundle              mem2Bundle,
    input  wire logic [wbPkg::REG_ADDR_W-1:0] rdAddrA,
    input  wire logic [wbPkg::REG_ADDR_W-1:0] rdAddrB,
    output logic [31:0]                      rdDataA,
    output logic [31:0]                      rdDataB,
    output logic [31:0]                      hi,
    output logic [31:0]                      lo
);

    import wbPkg::*;

    wbBundle     wbStage;
    logic [31:0] loadData;

    wbStageReg stageReg0 (
        .clk        (clk),
        .reset      (reset),
        .wbFlush    (wbFlush),
        .wbWr       (wbWr),
        .mem2Bundle (mem2Bundle),
        .wbStage    (wbStage)
    );

    // result holds the load address, so its low bits pick the lane
    loadFormatter loadFmt0 (
        .instr    (wbStage.instr),
        .addrLow  (wbStage.result[1:0]),
        .dmOut    (wbStage.dmOut),
        .loadData (loadData)
    );

    hiLoRegs hiLo0 (
        .clk    (clk),
        .reset  (reset),
        .instr  (wbStage.instr),
        .regsWr (wbStage.regsWr),
        .outB   (wbStage.outB),
        .result (wbStage.result),
        .hi     (hi),
        .lo     (lo)
    );

    gprFile gpr0 (
        .clk      (clk),
        .reset    (reset),
        .wbSel    (wbStage.wbSel),
        .dst      (wbStage.dst),
        .rfWr     (wbStage.regsWr.rfWr),
        .result   (wbStage.result),
        .loadData (loadData),
        .hi       (hi),
        .lo       (lo),
        .rdAddrA  (rdAddrA),
        .rdAddrB  (rdAddrB),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB)
    );

endmodule

`default_nettype wire

// File: rtl/gprFile.sv
////////////////////
// general register file
// writeback select, 32 entries, two bypassed read ports
////////////////////

`default_nettype none

module gprFile (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic [1:0]                  wbSel,
    input  wire logic [wbPkg::REG_ADDR_W-1:0] dst,
    input  wire logic                        rfWr,
    input  wire logic [31:0]                 result,
    input  wire logic [31:0]                 loadData,
    input  wire logic [31:0]                 hi,
    input  wire logic [31:0]                 lo,
    input  wire logic [wbPkg::REG_ADDR_W-1:0] rdAddrA,
    input  wire logic [wbPkg::REG_ADDR_W-1:0] rdAddrB,
    output logic [31:0]                      rdDataA,
    output logic [31:0]                      rdDataB
);

    import wbPkg::*;

    logic [31:0] regs [REG_COUNT];
    logic [31:0] wrValue;
    logic        wrEn;

    ////////////////////
    // write side
    ////////////////////

    always_comb begin
        case (wbSel)
            WB_SEL_RESULT: wrValue = result;
            WB_SEL_LOAD:   wrValue = loadData;
            WB_SEL_HI:     wrValue = hi;
            WB_SEL_LO:     wrValue = lo;
            default:       wrValue = result;
        endcase
    end

    // r0 is never written
    assign wrEn = rfWr && (dst != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[dst] <= wrValue;
        end
    end

    ////////////////////
    // read side
    ////////////////////

    // pending write is forwarded so a same-cycle read sees the new value
    function automatic logic [31:0] readPort(input logic [REG_ADDR_W-1:0] addr);
        logic [31:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (wrEn && (addr == dst)) begin
            data = wrValue;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rdDataA = readPort(rdAddrA);
        rdDataB = readPort(rdAddrB);
    end

endmodule

`default_nettype wire

// File: rtl/hiLoRegs.sv
////////////////////
// HI and LO registers
////////////////////

`default_nettype none

module hiLoRegs (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire wbPkg::instrWord  instr,
    input  wire wbPkg::regsWrType regsWr,
    input  wire logic [31:0]      outB,
    input  wire logic [31:0]      result,
    output logic [31:0]           hi,
    output logic [31:0]           lo
);

    import wbPkg::*;

    logic isMult;
    logic isMthi;
    logic isMtlo;

    assign isMult = (instr.rType.funct == FN_MULT) || (instr.rType.funct == FN_MULTU);
    assign isMthi = (instr.rType.funct == FN_MTHI);
    assign isMtlo = (instr.rType.funct == FN_MTLO);

    // multiply delivers the high half on outB and the low half on result
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else begin
            if (regsWr.hiWr) begin
                hi <= outB;
            end
            if (regsWr.loWr) begin
                lo <= isMtlo ? outB : result;
            end
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // only a multiply writes both halves at once
    bothOnlyOnMult: assert property (
        @(posedge clk) disable iff (reset)
        (regsWr.hiWr && regsWr.loWr) |-> isMult
    ) else $error("HI and LO written together by a non-multiply");

    hiWrSource: assert property (
        @(posedge clk) disable iff (reset)
        regsWr.hiWr |-> (isMthi || isMult)
    ) else $error("HI written by an unexpected funct");

endmodule

`default_nettype wire

// File: rtl/loadFormatter.sv
////////////////////
// load data formatting
// lane select and sign or zero extension of the memory word
////////////////////

`default_nettype none

module loadFormatter (
    input  wire wbPkg::instrWord instr,
    input  wire logic [1:0]      addrLow,
    input  wire logic [31:0]     dmOut,
    output logic [31:0]          loadData
);

    import wbPkg::*;

    logic        isByte;
    logic        isHalf;
    logic        isSigned;
    logic [7:0]  byteLane;
    logic [15:0] halfLane;

    // width and signedness from the I-type opcode
    always_comb begin
        isByte   = 1'b0;
        isHalf   = 1'b0;
        isSigned = 1'b0;
        case (instr.iType.opcode)
            OP_LB: begin
                isByte   = 1'b1;
                isSigned = 1'b1;
            end
            OP_LBU: begin
                isByte = 1'b1;
            end
            OP_LH: begin
                isHalf   = 1'b1;
                isSigned = 1'b1;
            end
            OP_LHU: begin
                isHalf = 1'b1;
            end
            // lw and anything else take the word as it is
            OP_LW:   ;
            default: ;
        endcase
    end

    // little-endian lanes
    always_comb begin
        case (addrLow)
            2'd0:    byteLane = dmOut[7:0];
            2'd1:    byteLane = dmOut[15:8];
            2'd2:    byteLane = dmOut[23:16];
            default: byteLane = dmOut[31:24];
        endcase
    end

    assign halfLane = addrLow[1] ? dmOut[31:16] : dmOut[15:0];

    always_comb begin
        if (isByte) begin
            loadData = {{24{isSigned & byteLane[7]}}, byteLane};
        end else if (isHalf) begin
            loadData = {{16{isSigned & halfLane[15]}}, halfLane};
        end else begin
            loadData = dmOut;
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // misaligned halfwords are trapped before memory, so none arrive here
    always_comb begin
        if (isHalf) begin
            halfAligned: assert (addrLow[0] == 1'b0)
                else $error("halfword load with odd address");
        end
    end

endmodule

`default_nettype wire

// File: rtl/wbStageReg.sv
////////////////////
// memory-to-writeback stage register
// flush clears the bundle, write enable low holds it
////////////////////

`default_nettype none

module wbStageReg (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          wbFlush,
    input  wire logic          wbWr,
    input  wire wbPkg::wbBundle mem2Bundle,
    output wbPkg::wbBundle     wbStage
);

    import wbPkg::*;

    // flush wins over the write enable
    always_ff @(posedge clk) begin
        if (reset || wbFlush) begin
            wbStage <= '0;
        end else if (wbWr) begin
            wbStage <= mem2Bundle;
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // a flushed slot must not commit anything downstream
    flushKillsEnables: assert property (
        @(posedge clk) disable iff (reset)
        wbFlush |=> (wbStage.regsWr == regsWrType'('0))
    ) else $error("wbStage carries write enables after a flush");

endmodule

`default_nettype wire

// File: common/wbPkg.sv
////////////////////
// shared types and encodings for the writeback tail
// instruction union, write enables, stage bundle, opcodes and functs
////////////////////

`default_nettype none

package wbPkg;

    ////////////////////
    // register file geometry
    ////////////////////
    localparam int REG_COUNT  = 32;
    localparam int REG_ADDR_W = 5;

    ////////////////////
    // writeback source select
    ////////////////////
    localparam logic [1:0] WB_SEL_RESULT = 2'd0;
    localparam logic [1:0] WB_SEL_LOAD   = 2'd1;
    localparam logic [1:0] WB_SEL_HI     = 2'd2;
    localparam logic [1:0] WB_SEL_LO     = 2'd3;

    // load opcodes, standard MIPS encodings
    localparam logic [5:0] OP_LB  = 6'b100000;
    localparam logic [5:0] OP_LH  = 6'b100001;
    localparam logic [5:0] OP_LW  = 6'b100011;
    localparam logic [5:0] OP_LBU = 6'b100100;
    localparam logic [5:0] OP_LHU = 6'b100101;

    // SPECIAL functs that touch HI/LO
    localparam logic [5:0] FN_MTHI  = 6'b010001;
    localparam logic [5:0] FN_MTLO  = 6'b010011;
    localparam logic [5:0] FN_MULT  = 6'b011000;
    localparam logic [5:0] FN_MULTU = 6'b011001;

    ////////////////////
    // instruction word views
    ////////////////////
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeFields;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeFields;

    // one word, read as R-type by HI/LO and as I-type by the load path
    typedef union packed {
        rTypeFields rType;
        iTypeFields iType;
    } instrWord;

    // enables already settled by exception handling
    // cp0Wr is carried along but not consumed here
    typedef struct packed {
        logic rfWr;
        logic hiWr;
        logic loWr;
        logic cp0Wr;
    } regsWrType;

    // memory-to-writeback bundle
    typedef struct packed {
        logic [31:0]           pc;
        instrWord              instr;
        logic [1:0]            wbSel;
        logic [REG_ADDR_W-1:0] dst;
        logic [31:0]           dmOut;
        logic [31:0]           outB;
        regsWrType             regsWr;
        logic [31:0]           result;
    } wbBundle;

endpackage

`default_nettype wire
